// ==== verilog/nocPkg.sv ====
`default_nettype none

package nocPkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ports and field widths
  localparam int numPorts = 5;
  localparam int portW = 3;
  localparam int lenW = 12;

  localparam logic [portW-1:0] portLocal = 3'd0;
  localparam logic [portW-1:0] portNorth = 3'd1;
  localparam logic [portW-1:0] portEast = 3'd2;
  localparam logic [portW-1:0] portWest = 3'd3;
  localparam logic [portW-1:0] portSouth = 3'd4;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // flit id codes, anything else is invalid
  localparam logic [2:0] idHeader = 3'd1;
  localparam logic [2:0] idBody = 3'd2;
  localparam logic [2:0] idTail = 3'd3;

  typedef struct packed {
    logic [2:0] id;
    logic [lenW-1:0] length;  // whole packet, header included.
    logic spare;
  } headerT;

  typedef struct packed {
    logic [2:0] id;
    logic [12:0] payload;
  } dataT;

  typedef union packed {
    headerT hdr;
    dataT data;
  } flitT;

endpackage

`default_nettype wire

// ==== verilog/linkReceiver.sv ====
`timescale 1ns/1ps
`default_nettype none

module linkReceiver
(
  input  logic clk,
  input  logic rst,
  input  nocPkg::flitT flitIn,
  input  logic flitValid,
  output nocPkg::flitT wrFlit,
  output logic wrEn,
  output logic protocolError
);
  import nocPkg::*;

  logic inPacket;
  logic [lenW-1:0] remaining;  // flits still owed to the open packet.
  logic [2:0] id;
  logic [lenW-1:0] hdrLen;
  logic accept;

  assign id = flitIn.data.id;
  assign hdrLen = flitIn.hdr.length;

  // framing check on the incoming flit
  always_comb
  begin
    if (!inPacket)
      accept = (id == idHeader) && (hdrLen > 1);
    else if (remaining == 1)
      accept = (id == idTail);  // last flit must close.
    else
      accept = (id == idBody);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      inPacket <= 1'b0;
      remaining <= '0;
      wrEn <= 1'b0;
      protocolError <= 1'b0;
    end
    else
    begin
      wrEn <= flitValid && accept;
      protocolError <= flitValid && !accept;
      if (flitValid && !accept)
        inPacket <= 1'b0;  // any fault closes the packet.
      else if (flitValid && !inPacket)
      begin
        inPacket <= 1'b1;
        remaining <= hdrLen - 1'b1;
      end
      else if (flitValid)
      begin
        remaining <= remaining - 1'b1;
        if (remaining == 1)
          inPacket <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (flitValid)
      wrFlit <= flitIn;
  end

endmodule

`default_nettype wire

// ==== verilog/flitFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module flitFifo
#(
  parameter int fifoDepth = 8
)
(
  input  logic clk,
  input  logic rst,
  input  nocPkg::flitT wrFlit,
  input  logic wrEn,
  input  logic rdEn,
  output nocPkg::flitT headFlit,
  output logic empty,
  output logic overflow
);
  import nocPkg::*;

  localparam int ptrW = $clog2(fifoDepth);

  flitT mem [fifoDepth];
  logic [ptrW:0] wrPtr;  // msb is the wrap bit.
  logic [ptrW:0] rdPtr;
  logic full;

  assign empty = (wrPtr == rdPtr);
  assign full = (wrPtr[ptrW] != rdPtr[ptrW]) &&
                (wrPtr[ptrW-1:0] == rdPtr[ptrW-1:0]);
  assign headFlit = mem[rdPtr[ptrW-1:0]];  // fall-through head.

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      overflow <= 1'b0;
    end
    else
    begin
      overflow <= wrEn && full;  // same-cycle pop does not help.
      if (wrEn && !full)
        wrPtr <= wrPtr + 1'b1;
      if (rdEn && !empty)
        rdPtr <= rdPtr + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wrEn && !full)
      mem[wrPtr[ptrW-1:0]] <= wrFlit;
  end

endmodule

`default_nettype wire

// ==== verilog/grantTimer.sv ====
`timescale 1ns/1ps
`default_nettype none

module grantTimer
(
  input  logic clk,
  input  logic rst,
  input  nocPkg::flitT headFlit,
  input  logic pop,
  input  logic granted,
  output logic timesUp
);
  import nocPkg::*;

  logic [lenW-1:0] count;  // pops done in this grant.
  logic [lenW-1:0] lenReg;
  logic [lenW-1:0] effLen;
  logic headerPop;

  assign headerPop = (headFlit.hdr.id == idHeader) && (count == '0);
  assign effLen = headerPop ? headFlit.hdr.length : lenReg;

  // high on the pop that completes the packet, so the grant moves at that edge
  assign timesUp = pop && ((count + 1'b1) == effLen);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
      lenReg <= '0;
    end
    else
    begin
      if (pop && headerPop)
        lenReg <= headFlit.hdr.length;
      if (!granted)
        count <= '0;
      else if (pop)
        count <= timesUp ? '0 : count + 1'b1;  // restart for a regrant.
    end
  end

endmodule

`default_nettype wire

// ==== verilog/switchArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module switchArbiter
(
  input  logic clk,
  input  logic rst,
  input  logic [nocPkg::numPorts-1:0] req,
  input  nocPkg::flitT headFlit0,
  input  nocPkg::flitT headFlit1,
  input  nocPkg::flitT headFlit2,
  input  nocPkg::flitT headFlit3,
  input  nocPkg::flitT headFlit4,
  output logic [nocPkg::numPorts-1:0] popSel
);
  import nocPkg::*;

  logic [numPorts:0] grantState;  // bit 0 is idle.
  logic [numPorts:0] nextState;
  logic [numPorts-1:0] grant;
  logic [numPorts-1:0] timesUp;
  logic [numPorts-1:0] nextPick;
  logic [portW-1:0] startPort;
  logic hold;
  flitT heads [numPorts];

  // first requester at or after start, wrapping around
  function automatic logic [numPorts-1:0] pickNext(input logic [numPorts-1:0] reqs,
                                                   input int start);
    logic [numPorts-1:0] pick;
    int idx;
    pick = '0;
    for (int k = numPorts - 1; k >= 0; k--)
    begin
      idx = (start + k) % numPorts;
      if (reqs[idx])
      begin
        pick = '0;
        pick[idx] = 1'b1;
      end
    end
    return pick;
  endfunction

  assign heads[portLocal] = headFlit0;
  assign heads[portNorth] = headFlit1;
  assign heads[portEast] = headFlit2;
  assign heads[portWest] = headFlit3;
  assign heads[portSouth] = headFlit4;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // per-port packet timers
  for (genvar i = 0; i < numPorts; i++)
  begin : gTimer
    grantTimer timer0
    (
      .clk(clk),
      .rst(rst),
      .headFlit(heads[i]),
      .pop(popSel[i]),
      .granted(grant[i]),
      .timesUp(timesUp[i])
    );
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // rotating priority
  assign grant = grantState[numPorts:1];
  assign popSel = grant & req;
  assign hold = |(grant & req & ~timesUp);

  always_comb
  begin
    startPort = portLocal;  // idle searches from Local.
    for (int i = 0; i < numPorts; i++)
    begin
      if (grant[i])
        startPort = portW'((i + 1) % numPorts);  // search past the owner.
    end
  end

  assign nextPick = pickNext(req, startPort);

  always_comb
  begin
    if (hold)
      nextState = grantState;
    else
      nextState = {nextPick, ~|nextPick};  // idle when nobody asks.
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      grantState <= {{numPorts{1'b0}}, 1'b1};
    else
      grantState <= nextState;
  end

endmodule

`default_nettype wire

// ==== verilog/outputStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module outputStage
(
  input  logic clk,
  input  logic rst,
  input  nocPkg::flitT headFlit0,
  input  nocPkg::flitT headFlit1,
  input  nocPkg::flitT headFlit2,
  input  nocPkg::flitT headFlit3,
  input  nocPkg::flitT headFlit4,
  input  logic [nocPkg::numPorts-1:0] empty,
  output logic [nocPkg::numPorts-1:0] popSel,
  output nocPkg::flitT outFlit,
  output logic outValid,
  output logic [nocPkg::portW-1:0] outPort
);
  import nocPkg::*;

  flitT heads [numPorts];
  flitT selFlit;
  logic [portW-1:0] selPort;

  assign heads[portLocal] = headFlit0;
  assign heads[portNorth] = headFlit1;
  assign heads[portEast] = headFlit2;
  assign heads[portWest] = headFlit3;
  assign heads[portSouth] = headFlit4;

  switchArbiter arb0
  (
    .clk(clk),
    .rst(rst),
    .req(~empty),  // a non-empty FIFO requests.
    .headFlit0(headFlit0),
    .headFlit1(headFlit1),
    .headFlit2(headFlit2),
    .headFlit3(headFlit3),
    .headFlit4(headFlit4),
    .popSel(popSel)
  );

  always_comb
  begin
    selFlit = '0;
    selPort = '0;
    for (int i = 0; i < numPorts; i++)
    begin
      if (popSel[i])
      begin
        selFlit = heads[i];
        selPort = portW'(i);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= |popSel;
  end

  always_ff @(posedge clk)
  begin
    if (|popSel)
    begin
      outFlit <= selFlit;
      outPort <= selPort;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/routerOutputPort.sv ====
`timescale 1ns/1ps
`default_nettype none

module routerOutputPort
#(
  parameter int fifoDepth = 8
)
(
  input  logic clk,
  input  logic rst,
  input  nocPkg::flitT flitIn0,
  input  nocPkg::flitT flitIn1,
  input  nocPkg::flitT flitIn2,
  input  nocPkg::flitT flitIn3,
  input  nocPkg::flitT flitIn4,
  input  logic [nocPkg::numPorts-1:0] flitValid,
  output nocPkg::flitT outFlit,
  output logic outValid,
  output logic [nocPkg::portW-1:0] outPort,
  output logic [nocPkg::numPorts-1:0] protocolError,
  output logic [nocPkg::numPorts-1:0] overflow
);
  import nocPkg::*;

  flitT linkFlit [numPorts];
  flitT wrFlit [numPorts];
  flitT headFlit [numPorts];
  logic [numPorts-1:0] wrEn;
  logic [numPorts-1:0] empty;
  logic [numPorts-1:0] popSel;

  assign linkFlit[portLocal] = flitIn0;
  assign linkFlit[portNorth] = flitIn1;
  assign linkFlit[portEast] = flitIn2;
  assign linkFlit[portWest] = flitIn3;
  assign linkFlit[portSouth] = flitIn4;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // receiver and FIFO per input link
  for (genvar i = 0; i < numPorts; i++)
  begin : gPort
    linkReceiver rx0
    (
      .clk(clk),
      .rst(rst),
      .flitIn(linkFlit[i]),
      .flitValid(flitValid[i]),
      .wrFlit(wrFlit[i]),
      .wrEn(wrEn[i]),
      .protocolError(protocolError[i])
    );

    flitFifo #(.fifoDepth(fifoDepth)) fifo0
    (
      .clk(clk),
      .rst(rst),
      .wrFlit(wrFlit[i]),
      .wrEn(wrEn[i]),
      .rdEn(popSel[i]),
      .headFlit(headFlit[i]),
      .empty(empty[i]),
      .overflow(overflow[i])
    );
  end

  outputStage out0
  (
    .clk(clk),
    .rst(rst),
    .headFlit0(headFlit[portLocal]),
    .headFlit1(headFlit[portNorth]),
    .headFlit2(headFlit[portEast]),
    .headFlit3(headFlit[portWest]),
    .headFlit4(headFlit[portSouth]),
    .empty(empty),
    .popSel(popSel),
    .outFlit(outFlit),
    .outValid(outValid),
    .outPort(outPort)
  );

endmodule

`default_nettype wire

// ==== verif/switchArbiter_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module switchArbiterProps
(
  input  logic clk,
  input  logic rst,
  input  logic [nocPkg::numPorts:0] grantState,
  input  logic [nocPkg::numPorts-1:0] req,
  input  logic [nocPkg::numPorts-1:0] popSel,
  input  logic [nocPkg::numPorts-1:0] timesUp
);
  import nocPkg::*;

  logic [numPorts-1:0] grant;

  assign grant = grantState[numPorts:1];  // drop the idle bit.

  stateOneHot: assert property (@(posedge clk) disable iff (rst)
    $onehot(grantState))
    else $error("grant state is not one-hot");

  popOneHot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(popSel))
    else $error("popSel has more than one bit set");

  popGranted: assert property (@(posedge clk) disable iff (rst)
    (popSel & ~(grant & req)) == '0)
    else $error("popSel on a port that is not granted and requesting");

  // an owner that still requests and has flits left keeps the link
  grantHeld: assert property (@(posedge clk) disable iff (rst)
    |(grant & req & ~timesUp) |=> $stable(grantState))
    else $error("grant moved while the owner still had flits left");

endmodule

bind switchArbiter switchArbiterProps props0
(
  .clk(clk),
  .rst(rst),
  .grantState(grantState),
  .req(req),
  .popSel(popSel),
  .timesUp(timesUp)
);

`default_nettype wire

// ==== verif/routerTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module routerTb;
  import nocPkg::*;

  localparam int fifoDepth = 8;
  localparam int numSteps = 15;
  localparam int maxCyc = 600;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus table with fault codes 1 lone body, 2 early tail, 3 length 1, 4 overflow
  int stepPort [numSteps] = '{0, 0, 1, 2, 3, 4, 1, 2, 4, 0, 1, 2, 4, 0, 3};
  int stepWait [numSteps] = '{20, 30, 0, 0, 0, 0, 8, 40, 0, 2, 40, 40, 40, 40, 2};
  int stepLen [numSteps] = '{4, 3, 5, 2, 4, 3, 3, 6, 2, 7, 0, 4, 1, 20, 0};
  int stepFault [numSteps] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 2, 3, 0, 4};

  logic clk;
  logic rst;
  logic [15:0] drvFlit [numPorts];
  logic [numPorts-1:0] flitValid;
  flitT flitIn0, flitIn1, flitIn2, flitIn3, flitIn4;
  flitT outFlit;
  logic outValid;
  logic [portW-1:0] outPort;
  logic [numPorts-1:0] protocolError;
  logic [numPorts-1:0] overflow;

  logic [15:0] schedFlit [maxCyc][numPorts];
  logic schedValid [maxCyc][numPorts];
  logic [15:0] expFlit [numPorts][$];
  int pktCount [numPorts][$];  // flits that reach the output.
  int pktLen [numPorts][$];
  int pktStrobe [numPorts][$];
  int expErr [numPorts];
  int expOvf [numPorts];
  int errSeen [numPorts];
  int ovfSeen [numPorts];
  integer seed;
  int cyc, checks, mismatches, otherErrors, watchdogCycles;
  int curPort, curLeft, curCount, curLen, lastPort, skip, expPort, rotateAt;
  bit lastNormal, tableReady, started;

  assign flitIn0 = drvFlit[0];
  assign flitIn1 = drvFlit[1];
  assign flitIn2 = drvFlit[2];
  assign flitIn3 = drvFlit[3];
  assign flitIn4 = drvFlit[4];

  routerOutputPort #(.fifoDepth(fifoDepth)) dut0
  (
    .clk(clk),
    .rst(rst),
    .flitIn0(flitIn0),
    .flitIn1(flitIn1),
    .flitIn2(flitIn2),
    .flitIn3(flitIn3),
    .flitIn4(flitIn4),
    .flitValid(flitValid),
    .outFlit(outFlit),
    .outValid(outValid),
    .outPort(outPort),
    .protocolError(protocolError),
    .overflow(overflow)
  );

  always #2 clk = ~clk;

  always @(posedge clk)
    cyc <= cyc + 1;

  // first port from start, wrapping, whose header was visible at decision time
  function automatic int eligiblePort(input int c, input int start);
    int idx;
    for (int k = 0; k < numPorts; k++)
    begin
      idx = (start + k) % numPorts;
      if (pktStrobe[idx].size() > 0 && pktStrobe[idx][0] <= c - 4)
        return idx;
    end
    return -1;
  endfunction

  task automatic scheduleFlit(input int c, input int p, input logic [15:0] f);
    if (schedValid[c][p])
    begin
      otherErrors++;
      $display("stimulus table overlaps itself on port %0d, cycle %0d", p, c);
    end
    schedValid[c][p] = 1'b1;
    schedFlit[c][p] = f;
  endtask

  // places one table step and records what should come out
  task automatic buildStep(input int s, input int start);
    int p, len, kept;
    logic [15:0] f;
    p = stepPort[s];
    len = (stepFault[s] == 4) ? fifoDepth + 1 : stepLen[s];
    kept = (stepFault[s] == 4) ? fifoDepth : len;
    if (stepFault[s] == 1)
    begin
      scheduleFlit(start, p, {idBody, 13'($random(seed))});
      expErr[p]++;
      return;
    end
    scheduleFlit(start, p, {idHeader, lenW'(len), 1'b0});
    if (stepFault[s] == 3)
    begin
      expErr[p]++;
      return;
    end
    expFlit[p].push_back({idHeader, lenW'(len), 1'b0});
    pktStrobe[p].push_back(start);
    pktLen[p].push_back(len);
    if (stepFault[s] == 2)
    begin
      scheduleFlit(start + 1, p, {idTail, 13'($random(seed))});
      expErr[p]++;
      pktCount[p].push_back(1);  // only the header gets through.
      return;
    end
    pktCount[p].push_back(kept);
    for (int i = 1; i < len; i++)
    begin
      f = {(i == len - 1) ? idTail : idBody, 13'($random(seed))};
      scheduleFlit(start + i, p, f);
      if (i < kept)
        expFlit[p].push_back(f);
    end
    if (stepFault[s] == 4)
      expOvf[p]++;
  endtask

  // drive 1 ns after the edge
  always @(posedge clk)
  begin
    #1;
    for (int i = 0; i < numPorts; i++)
    begin
      flitValid[i] <= (cyc < maxCyc) ? schedValid[cyc][i] : 1'b0;
      drvFlit[i] <= (cyc < maxCyc) ? schedFlit[cyc][i] : 16'h0;
    end
  end

  always @(negedge clk)
  begin
    if (started)
    begin
      for (int i = 0; i < numPorts; i++)
      begin
        if (protocolError[i])
          errSeen[i]++;
        if (overflow[i])
          ovfSeen[i]++;
      end
      if (outValid)
      begin
        if (curLeft == 0)
        begin
          expPort = eligiblePort(cyc, (cyc == rotateAt) ? (lastPort + 1) % numPorts : 0);
          if (expPort < 0)
          begin
            otherErrors++;
            $display("unexpected flit %h from port %0d at %0t", outFlit, outPort, $time);
          end
          else
          begin
            curPort = expPort;
            curCount = pktCount[curPort].pop_front();
            curLen = pktLen[curPort].pop_front();
            void'(pktStrobe[curPort].pop_front());
            curLeft = curCount;
          end
        end
        if (curLeft > 0)
        begin
          checks += 2;
          if (outPort !== curPort)
          begin
            mismatches++;
            $display("mismatch at %0t: outPort %0d, expected %0d", $time, outPort, curPort);
          end
          if (outFlit !== expFlit[curPort][0])
          begin
            mismatches++;
            $display("mismatch at %0t: outFlit %h, expected %h", $time, outFlit,
                     expFlit[curPort][0]);
          end
          void'(expFlit[curPort].pop_front());
          curLeft--;
          if (curLeft == 0)
          begin
            lastPort = curPort;
            lastNormal = (curCount == curLen);
            skip = lastNormal ? 0 : 1;  // a cut packet ends one cycle late.
            rotateAt = cyc + 1 + skip;  // next owner searched past this port.
          end
        end
      end
      else if (curLeft > 0)
      begin
        mismatches++;
        $display("mismatch at %0t: bubble inside packet from port %0d", $time, curPort);
        repeat (curLeft)
          void'(expFlit[curPort].pop_front());
        curLeft = 0;
      end
      else if (skip > 0)
        skip--;
      else if (eligiblePort(cyc, 0) >= 0)
      begin
        mismatches++;
        $display("mismatch at %0t: output idle while port %0d waits", $time,
                 eligiblePort(cyc, 0));
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // watchdog
  initial
  begin
    wait (tableReady);
    #(watchdogCycles * 4);
    $display("timeout: the output did not drain in %0d cycles", watchdogCycles);
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    int cursor;
    int total;
    bit drained;
    clk = 1'b0;
    rst = 1'b1;
    cyc = 0;
    flitValid = '0;
    for (int i = 0; i < numPorts; i++)
      drvFlit[i] = 16'h0;
    seed = 32'h2f86_0ee8;
    for (int c = 0; c < maxCyc; c++)
      for (int i = 0; i < numPorts; i++)
      begin
        schedValid[c][i] = 1'b0;
        schedFlit[c][i] = 16'h0;
      end
    cursor = 12;
    total = 0;
    for (int s = 0; s < numSteps; s++)
    begin
      cursor += stepWait[s];
      buildStep(s, cursor);
      total += stepLen[s] + fifoDepth;
    end
    watchdogCycles = cursor + total + 100;
    tableReady = 1'b1;
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
    started = 1'b1;
    drained = 1'b0;
    while (!drained)
    begin
      @(negedge clk);
      drained = (cyc > cursor + 4) && (curLeft == 0);
      for (int i = 0; i < numPorts; i++)
        if (pktCount[i].size() > 0)
          drained = 1'b0;
    end
    repeat (10) @(negedge clk);  // catch stray flits and pulses.
    for (int i = 0; i < numPorts; i++)
    begin
      checks += 2;
      if (errSeen[i] != expErr[i])
      begin
        mismatches++;
        $display("mismatch at %0t: port %0d protocolError pulses %0d, expected %0d",
                 $time, i, errSeen[i], expErr[i]);
      end
      if (ovfSeen[i] != expOvf[i])
      begin
        mismatches++;
        $display("mismatch at %0t: port %0d overflow pulses %0d, expected %0d",
                 $time, i, ovfSeen[i], expOvf[i]);
      end
    end
    $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, otherErrors);
    if (mismatches == 0 && otherErrors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
verilog/nocPkg.sv
verilog/linkReceiver.sv
verilog/flitFifo.sv
verilog/grantTimer.sv
verilog/switchArbiter.sv
verilog/outputStage.sv
verilog/routerOutputPort.sv
verif/switchArbiter_props.sv
verif/routerTb.sv

// ==== Bender.yml ====
package:
  name: router_output_port

sources:
  - files:
      - verilog/nocPkg.sv
      - verilog/linkReceiver.sv
      - verilog/flitFifo.sv
      - verilog/grantTimer.sv
      - verilog/switchArbiter.sv
      - verilog/outputStage.sv
      - verilog/routerOutputPort.sv
  - target: simulation
    files:
      - verif/switchArbiter_props.sv
      - verif/routerTb.sv

# top levels: routerOutputPort for the design, routerTb for simulation
# file list for direct simulator runs: compile.f
